// File: include/axiBridgeDefs.svh
// AXI bridge field widths and codes
`ifndef AXI_BRIDGE_DEFS_SVH
`define AXI_BRIDGE_DEFS_SVH

// fixed 32-bit data path
localparam int dataWidth = 32;
localparam int strbWidth = dataWidth / 8;
localparam int laneBits  = 2;   // address bits that pick a byte lane
localparam int lenWidth  = 4;   // AXI3 burst length field

localparam logic [1:0] burstFixed = 2'b00;
localparam logic [1:0] burstIncr  = 2'b01;

localparam logic [1:0] respOkay   = 2'b00;
localparam logic [1:0] respSlvErr = 2'b10;

`endif

// File: rtl/axiBridgePkg.sv
// AXI bridge shared package
`default_nettype none

package axiBridgePkg;

  // default widths, overridden through module parameters
  localparam int idWidth   = 8;
  localparam int addrWidth = 32;

  `include "axiBridgeDefs.svh"

  // write channel controller states
  typedef enum logic [2:0] {
    wsIdle,
    wsAccept,    // AWREADY pulse, counter load
    wsData,      // waiting for a W beat
    wsReq,       // REQ high until ACK seen
    wsRelease,   // waiting for ACK to fall
    wsResp       // BVALID held until BREADY
  } writeStateT;

  // read channel controller states
  typedef enum logic [2:0] {
    rsIdle,
    rsAccept,
    rsReq,
    rsRelease,
    rsBeat       // RVALID held until RREADY
  } readStateT;

endpackage

`default_nettype wire

// File: rtl/transferPort.sv
// transfer port arbiter and ACK synchronizer
`timescale 1ns/10ps
`default_nettype none

module transferPort import axiBridgePkg::*; #(
  parameter int addrWidth = axiBridgePkg::addrWidth
) (
  input  wire                  ACLK,
  input  wire                  ARESETn,
  input  wire                  AWVALID,
  input  wire                  ARVALID,
  input  wire                  wrDone,
  input  wire                  rdDone,
  input  wire                  wrReq,
  input  wire [addrWidth-1:0]  wrAddr,
  input  wire [dataWidth-1:0]  wrData,
  input  wire [strbWidth-1:0]  wrBe,
  input  wire                  rdReq,
  input  wire [addrWidth-1:0]  rdAddr,
  input  wire [strbWidth-1:0]  rdBe,
  input  wire                  ACK,
  output logic                 wrGrant,
  output logic                 rdGrant,
  output logic                 ackSync,
  output logic                 REQ,
  output logic [addrWidth-1:0] ADDR,
  output logic                 WR,
  output logic [dataWidth-1:0] DATAW,
  output logic [strbWidth-1:0] BE
);

  logic ackMeta;   // first synchronizer stage

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      ackMeta <= 1'b0;
      ackSync <= 1'b0;
    end else begin
      ackMeta <= ACK;
      ackSync <= ackMeta;
    end
  end

  // -------------------------------------------------------------------------
  // grant, write first, held until the owner's done strobe
  // -------------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      wrGrant <= 1'b0;
      rdGrant <= 1'b0;
    end else if (wrGrant) begin
      if (wrDone) wrGrant <= 1'b0;
    end else if (rdGrant) begin
      if (rdDone) rdGrant <= 1'b0;
    end else if (AWVALID) begin
      wrGrant <= 1'b1;
    end else if (ARVALID) begin
      rdGrant <= 1'b1;
    end
  end

  always_comb begin
    REQ   = 1'b0;   // idle port
    ADDR  = '0;
    WR    = 1'b0;
    DATAW = '0;
    BE    = '0;
    if (wrGrant) begin
      REQ   = wrReq;
      ADDR  = wrAddr;
      WR    = 1'b1;
      DATAW = wrData;
      BE    = wrBe;
    end else if (rdGrant) begin
      REQ  = rdReq;
      ADDR = rdAddr;
      BE   = rdBe;
    end
  end

endmodule

`default_nettype wire

// File: rtl/burstAddressCounter.sv
// burst beat counter and address stepper
`timescale 1ns/10ps
`default_nettype none

module burstAddressCounter import axiBridgePkg::*; #(
  parameter int addrWidth = axiBridgePkg::addrWidth
) (
  input  wire                  ACLK,
  input  wire                  ARESETn,
  input  wire                  counterLoad,
  input  wire                  counterAdvance,
  input  wire [addrWidth-1:0]  burstStart,
  input  wire [lenWidth-1:0]   burstLen,
  input  wire [2:0]            burstSize,
  input  wire [1:0]            burstType,
  output logic [addrWidth-1:0] beatAddr,
  output logic                 lastBeat
);

  logic [lenWidth-1:0]  beatCount;
  logic [addrWidth-1:0] nextAddr;

  // fixed keeps the address, narrow incr adds the size, wide incr
  // moves to the next aligned word
  always_comb begin
    nextAddr = beatAddr;
    if (burstType == burstIncr) begin
      if (burstSize < laneBits) nextAddr = beatAddr + (addrWidth'(1) << burstSize);
      else nextAddr = {beatAddr[addrWidth-1:laneBits] + 1'b1, {laneBits{1'b0}}};
    end
  end

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) beatCount <= '0;
    else if (counterLoad) beatCount <= '0;
    else if (counterAdvance) beatCount <= beatCount + 1'b1;
  end

  always_ff @(posedge ACLK) begin
    if (counterLoad) beatAddr <= burstStart;
    else if (counterAdvance) beatAddr <= nextAddr;
  end

  assign lastBeat = (beatCount == burstLen);

endmodule

`default_nettype wire

// File: rtl/writeChannelFsm.sv
// AXI write channel burst controller
`timescale 1ns/10ps
`default_nettype none

module writeChannelFsm import axiBridgePkg::*; #(
  parameter int idWidth   = axiBridgePkg::idWidth,
  parameter int addrWidth = axiBridgePkg::addrWidth
) (
  input  wire                  ACLK,
  input  wire                  ARESETn,
  input  wire                  wrGrant,
  input  wire                  ackSync,
  input  wire [idWidth-1:0]    AWID,
  input  wire [addrWidth-1:0]  AWADDR,
  input  wire [lenWidth-1:0]   AWLEN,
  input  wire [2:0]            AWSIZE,
  input  wire [1:0]            AWBURST,
  output logic                 AWREADY,
  input  wire [idWidth-1:0]    WID,
  input  wire [dataWidth-1:0]  WDATA,
  input  wire [strbWidth-1:0]  WSTRB,
  input  wire                  WLAST,
  input  wire                  WVALID,
  output logic                 WREADY,
  output logic [idWidth-1:0]   BID,
  output logic [1:0]           BRESP,
  output logic                 BVALID,
  input  wire                  BREADY,
  output logic                 wrReq,
  output logic [addrWidth-1:0] wrAddr,
  output logic [dataWidth-1:0] wrData,
  output logic [strbWidth-1:0] wrBe,
  output logic                 wrDone,
  output logic                 counterLoad,
  output logic                 counterAdvance,
  output logic [addrWidth-1:0] burstStart,
  output logic [lenWidth-1:0]  burstLen,
  output logic [2:0]           burstSize,
  output logic [1:0]           burstType,
  input  wire [addrWidth-1:0]  beatAddr,
  input  wire                  lastBeat
);

  writeStateT state;
  logic       respErr;   // sticky for the whole burst

  assign wrAddr         = beatAddr;
  assign counterLoad    = (state == wsAccept);
  assign counterAdvance = (state == wsRelease) && !ackSync && !lastBeat;
  assign wrDone         = (state == wsResp) && BREADY;   // frees the port
  assign BRESP          = respErr ? respSlvErr : respOkay;

  // -------------------------------------------------------------------------
  // control
  // -------------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state   <= wsIdle;
      AWREADY <= 1'b0;
      WREADY  <= 1'b0;
      BVALID  <= 1'b0;
      wrReq   <= 1'b0;
      respErr <= 1'b0;
    end else begin
      case (state)
        wsIdle: if (wrGrant) begin
          AWREADY <= 1'b1;
          state   <= wsAccept;
        end
        wsAccept: begin
          AWREADY <= 1'b0;
          WREADY  <= 1'b1;
          respErr <= 1'b0;
          state   <= wsData;
        end
        wsData: if (WVALID) begin
          WREADY <= 1'b0;
          wrReq  <= 1'b1;
          if ((WID != BID) || (lastBeat && !WLAST)) respErr <= 1'b1;
          state  <= wsReq;
        end
        wsReq: if (ackSync) begin
          wrReq <= 1'b0;
          state <= wsRelease;
        end
        wsRelease: if (!ackSync) begin
          if (lastBeat) begin
            BVALID <= 1'b1;
            state  <= wsResp;
          end else begin
            WREADY <= 1'b1;   // next beat
            state  <= wsData;
          end
        end
        wsResp: if (BREADY) begin
          BVALID <= 1'b0;
          state  <= wsIdle;
        end
        default: state <= wsIdle;
      endcase
    end
  end

  // burst fields and beat payload
  always_ff @(posedge ACLK) begin
    if ((state == wsIdle) && wrGrant) begin
      BID        <= AWID;
      burstStart <= AWADDR;
      burstLen   <= AWLEN;
      burstSize  <= AWSIZE;
      burstType  <= (AWBURST == burstIncr) ? burstIncr : burstFixed;  // wrap acts as fixed
    end
    if ((state == wsData) && WVALID) begin
      wrData <= WDATA;
      wrBe   <= WSTRB;
    end
  end

endmodule

`default_nettype wire

// File: rtl/readChannelFsm.sv
// AXI read channel burst controller
`timescale 1ns/10ps
`default_nettype none

module readChannelFsm import axiBridgePkg::*; #(
  parameter int idWidth   = axiBridgePkg::idWidth,
  parameter int addrWidth = axiBridgePkg::addrWidth
) (
  input  wire                  ACLK,
  input  wire                  ARESETn,
  input  wire                  rdGrant,
  input  wire                  ackSync,
  input  wire [idWidth-1:0]    ARID,
  input  wire [addrWidth-1:0]  ARADDR,
  input  wire [lenWidth-1:0]   ARLEN,
  input  wire [2:0]            ARSIZE,
  input  wire [1:0]            ARBURST,
  output logic                 ARREADY,
  input  wire [dataWidth-1:0]  DATAR,
  output logic [idWidth-1:0]   RID,
  output logic [dataWidth-1:0] RDATA,
  output logic [1:0]           RRESP,
  output logic                 RLAST,
  output logic                 RVALID,
  input  wire                  RREADY,
  output logic                 rdReq,
  output logic [addrWidth-1:0] rdAddr,
  output logic [strbWidth-1:0] rdBe,
  output logic                 rdDone,
  output logic                 counterLoad,
  output logic                 counterAdvance,
  output logic [addrWidth-1:0] burstStart,
  output logic [lenWidth-1:0]  burstLen,
  output logic [2:0]           burstSize,
  output logic [1:0]           burstType,
  input  wire [addrWidth-1:0]  beatAddr,
  input  wire                  lastBeat
);

  readStateT state;

  // lanes touched by one beat, word size and up takes all lanes
  function automatic logic [strbWidth-1:0] laneEnable(input logic [laneBits-1:0] lane,
                                                      input logic [2:0] size);
    case (size)
      3'd0:    return strbWidth'(1) << lane;
      3'd1:    return strbWidth'(3) << lane;
      default: return '1;
    endcase
  endfunction

  assign rdAddr         = beatAddr;
  assign rdBe           = laneEnable(beatAddr[laneBits-1:0], burstSize);
  assign RRESP          = respOkay;
  assign counterLoad    = (state == rsAccept);
  assign counterAdvance = (state == rsBeat) && RREADY && !lastBeat;
  assign rdDone         = (state == rsBeat) && RREADY && lastBeat;

  // -------------------------------------------------------------------------
  // control
  // -------------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state   <= rsIdle;
      ARREADY <= 1'b0;
      rdReq   <= 1'b0;
      RVALID  <= 1'b0;
      RLAST   <= 1'b0;
    end else begin
      case (state)
        rsIdle: if (rdGrant) begin
          ARREADY <= 1'b1;
          state   <= rsAccept;
        end
        rsAccept: begin
          ARREADY <= 1'b0;
          rdReq   <= 1'b1;   // counter holds the start address next cycle
          state   <= rsReq;
        end
        rsReq: if (ackSync) begin
          rdReq <= 1'b0;
          state <= rsRelease;
        end
        rsRelease: if (!ackSync) begin
          RVALID <= 1'b1;
          RLAST  <= lastBeat;
          state  <= rsBeat;
        end
        rsBeat: if (RREADY) begin
          RVALID <= 1'b0;
          RLAST  <= 1'b0;
          if (lastBeat) begin
            state <= rsIdle;
          end else begin
            rdReq <= 1'b1;
            state <= rsReq;
          end
        end
        default: state <= rsIdle;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if ((state == rsIdle) && rdGrant) begin
      RID        <= ARID;
      burstStart <= ARADDR;
      burstLen   <= ARLEN;
      burstSize  <= ARSIZE;
      burstType  <= (ARBURST == burstIncr) ? burstIncr : burstFixed;
    end
    if ((state == rsReq) && ackSync) RDATA <= DATAR;   // ACK still high here
  end

endmodule

`default_nettype wire

// File: rtl/axiApbBridge.sv
// AXI to APB bridge front end
`timescale 1ns/10ps
`default_nettype none

module axiApbBridge import axiBridgePkg::*; #(
  parameter int idWidth   = axiBridgePkg::idWidth,
  parameter int addrWidth = axiBridgePkg::addrWidth
) (
  input  wire                  ACLK,
  input  wire                  ARESETn,
  // write address, data and response
  input  wire [idWidth-1:0]    AWID,
  input  wire [addrWidth-1:0]  AWADDR,
  input  wire [lenWidth-1:0]   AWLEN,
  input  wire [2:0]            AWSIZE,
  input  wire [1:0]            AWBURST,
  input  wire                  AWVALID,
  output logic                 AWREADY,
  input  wire [idWidth-1:0]    WID,
  input  wire [dataWidth-1:0]  WDATA,
  input  wire [strbWidth-1:0]  WSTRB,
  input  wire                  WLAST,
  input  wire                  WVALID,
  output logic                 WREADY,
  output logic [idWidth-1:0]   BID,
  output logic [1:0]           BRESP,
  output logic                 BVALID,
  input  wire                  BREADY,
  // read address and data
  input  wire [idWidth-1:0]    ARID,
  input  wire [addrWidth-1:0]  ARADDR,
  input  wire [lenWidth-1:0]   ARLEN,
  input  wire [2:0]            ARSIZE,
  input  wire [1:0]            ARBURST,
  input  wire                  ARVALID,
  output logic                 ARREADY,
  output logic [idWidth-1:0]   RID,
  output logic [dataWidth-1:0] RDATA,
  output logic [1:0]           RRESP,
  output logic                 RLAST,
  output logic                 RVALID,
  input  wire                  RREADY,
  // transfer port toward the APB side
  output logic                 REQ,
  input  wire                  ACK,
  output logic [addrWidth-1:0] ADDR,
  output logic                 WR,
  output logic [dataWidth-1:0] DATAW,
  input  wire [dataWidth-1:0]  DATAR,
  output logic [strbWidth-1:0] BE
);

  // -------------------------------------------------------------------------
  // internal nets
  // -------------------------------------------------------------------------
  logic                 wrGrant, rdGrant, ackSync;
  logic                 wrDone, rdDone;
  logic                 wrReq, rdReq;
  logic [addrWidth-1:0] wrAddr, rdAddr;
  logic [dataWidth-1:0] wrData;
  logic [strbWidth-1:0] wrBe, rdBe;

  logic                 wrLoad, wrAdvance, wrLastBeat;
  logic [addrWidth-1:0] wrStart, wrBeatAddr;
  logic [lenWidth-1:0]  wrLen;
  logic [2:0]           wrSize;
  logic [1:0]           wrType;

  logic                 rdLoad, rdAdvance, rdLastBeat;
  logic [addrWidth-1:0] rdStart, rdBeatAddr;
  logic [lenWidth-1:0]  rdLen;
  logic [2:0]           rdSize;
  logic [1:0]           rdType;

  // -------------------------------------------------------------------------
  // write side
  // -------------------------------------------------------------------------
  writeChannelFsm #(.idWidth(idWidth), .addrWidth(addrWidth)) uWrite (
    .ACLK(ACLK), .ARESETn(ARESETn), .wrGrant(wrGrant), .ackSync(ackSync),
    .AWID(AWID), .AWADDR(AWADDR), .AWLEN(AWLEN), .AWSIZE(AWSIZE),
    .AWBURST(AWBURST), .AWREADY(AWREADY),
    .WID(WID), .WDATA(WDATA), .WSTRB(WSTRB), .WLAST(WLAST), .WVALID(WVALID),
    .WREADY(WREADY), .BID(BID), .BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
    .wrReq(wrReq), .wrAddr(wrAddr), .wrData(wrData), .wrBe(wrBe), .wrDone(wrDone),
    .counterLoad(wrLoad), .counterAdvance(wrAdvance), .burstStart(wrStart),
    .burstLen(wrLen), .burstSize(wrSize), .burstType(wrType),
    .beatAddr(wrBeatAddr), .lastBeat(wrLastBeat)
  );

  burstAddressCounter #(.addrWidth(addrWidth)) uWrCounter (
    .ACLK(ACLK), .ARESETn(ARESETn), .counterLoad(wrLoad), .counterAdvance(wrAdvance),
    .burstStart(wrStart), .burstLen(wrLen), .burstSize(wrSize), .burstType(wrType),
    .beatAddr(wrBeatAddr), .lastBeat(wrLastBeat)
  );

  // -------------------------------------------------------------------------
  // read side
  // -------------------------------------------------------------------------
  readChannelFsm #(.idWidth(idWidth), .addrWidth(addrWidth)) uRead (
    .ACLK(ACLK), .ARESETn(ARESETn), .rdGrant(rdGrant), .ackSync(ackSync),
    .ARID(ARID), .ARADDR(ARADDR), .ARLEN(ARLEN), .ARSIZE(ARSIZE),
    .ARBURST(ARBURST), .ARREADY(ARREADY), .DATAR(DATAR),
    .RID(RID), .RDATA(RDATA), .RRESP(RRESP), .RLAST(RLAST), .RVALID(RVALID),
    .RREADY(RREADY), .rdReq(rdReq), .rdAddr(rdAddr), .rdBe(rdBe), .rdDone(rdDone),
    .counterLoad(rdLoad), .counterAdvance(rdAdvance), .burstStart(rdStart),
    .burstLen(rdLen), .burstSize(rdSize), .burstType(rdType),
    .beatAddr(rdBeatAddr), .lastBeat(rdLastBeat)
  );

  burstAddressCounter #(.addrWidth(addrWidth)) uRdCounter (
    .ACLK(ACLK), .ARESETn(ARESETn), .counterLoad(rdLoad), .counterAdvance(rdAdvance),
    .burstStart(rdStart), .burstLen(rdLen), .burstSize(rdSize), .burstType(rdType),
    .beatAddr(rdBeatAddr), .lastBeat(rdLastBeat)
  );

  // -------------------------------------------------------------------------
  // arbitration and REQ/ACK port
  // -------------------------------------------------------------------------
  transferPort #(.addrWidth(addrWidth)) uPort (
    .ACLK(ACLK), .ARESETn(ARESETn), .AWVALID(AWVALID), .ARVALID(ARVALID),
    .wrDone(wrDone), .rdDone(rdDone), .wrReq(wrReq), .wrAddr(wrAddr),
    .wrData(wrData), .wrBe(wrBe), .rdReq(rdReq), .rdAddr(rdAddr), .rdBe(rdBe),
    .ACK(ACK), .wrGrant(wrGrant), .rdGrant(rdGrant), .ackSync(ackSync),
    .REQ(REQ), .ADDR(ADDR), .WR(WR), .DATAW(DATAW), .BE(BE)
  );

endmodule

`default_nettype wire

// File: sim/tbChecker.sv
// transfer port and response checker
`timescale 1ns/10ps
`default_nettype none

module tbChecker import axiBridgePkg::*; (
  input  wire        ACLK,
  input  wire        ARESETn,
  input  wire        REQ,
  input  wire [31:0] ADDR,
  input  wire        WR,
  input  wire [31:0] DATAW,
  input  wire [3:0]  BE,
  input  wire        BVALID,
  input  wire        BREADY,
  input  wire [7:0]  BID,
  input  wire [1:0]  BRESP,
  input  wire        RVALID,
  input  wire        RREADY,
  input  wire [7:0]  RID,
  input  wire [31:0] RDATA,
  input  wire [1:0]  RRESP,
  input  wire        RLAST,
  output int         errorCount
);

  logic [68:0] xferQ[$];   // wr, addr, data, be
  logic [9:0]  respQ[$];   // id, resp
  logic [40:0] beatQ[$];   // id, data, last
  logic        reqPrev;

  initial begin
    errorCount = 0;
    reqPrev    = 1'b0;
  end

  task automatic expectTransfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] be);
    xferQ.push_back({wr, addr, data, be});
  endtask

  task automatic expectWriteResp(input logic [7:0] id, input logic [1:0] resp);
    respQ.push_back({id, resp});
  endtask

  task automatic expectReadBeat(input logic [7:0] id, input logic [31:0] data,
                                input logic last);
    beatQ.push_back({id, data, last});
  endtask

  function automatic int outstanding();
    return xferQ.size() + respQ.size() + beatQ.size();
  endfunction

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      errorCount++;
    end
  endtask

  // -------------------------------------------------------------------------
  // sampled mid-cycle, away from the driving edge
  // -------------------------------------------------------------------------
  always @(negedge ACLK) begin : monitor
    logic [68:0] x;
    logic [9:0]  b;
    logic [40:0] r;
    if (ARESETn && REQ && !reqPrev) begin   // one new transfer per REQ rise
      if (xferQ.size() == 0) begin
        $display("REQ raised while no transfer was expected");
        errorCount++;
      end else begin
        x = xferQ.pop_front();
        compareValue("WR", 32'(WR), 32'(x[68]));
        compareValue("ADDR", ADDR, x[67:36]);
        if (x[68]) compareValue("DATAW", DATAW, x[35:4]);
        compareValue("BE", 32'(BE), 32'(x[3:0]));
      end
    end
    reqPrev = REQ;
    if (ARESETn && BVALID && BREADY) begin
      if (respQ.size() == 0) begin
        $display("write response seen while none was expected");
        errorCount++;
      end else begin
        b = respQ.pop_front();
        compareValue("BID", 32'(BID), 32'(b[9:2]));
        compareValue("BRESP", 32'(BRESP), 32'(b[1:0]));
      end
    end
    if (ARESETn && RVALID && RREADY) begin
      if (beatQ.size() == 0) begin
        $display("read beat seen while none was expected");
        errorCount++;
      end else begin
        r = beatQ.pop_front();
        compareValue("RID", 32'(RID), 32'(r[40:33]));
        compareValue("RDATA", RDATA, r[32:1]);
        compareValue("RLAST", 32'(RLAST), 32'(r[0]));
        compareValue("RRESP", 32'(RRESP), 32'(respOkay));
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tbAxiApbBridge.sv
// AXI to APB bridge testbench
`timescale 1ns/10ps
`default_nettype none

module tbAxiApbBridge import axiBridgePkg::*; ;

  localparam int timeoutCycles = 2000;
  localparam int burstTests    = 8;
  localparam int driveDelay    = 2;
  // handshake selectors
  localparam int awChan = 0;
  localparam int wChan  = 1;
  localparam int bChan  = 2;
  localparam int arChan = 3;
  localparam int rChan  = 4;

  logic        ACLK, ARESETn;
  logic [7:0]  AWID, WID, ARID;
  logic [31:0] AWADDR, ARADDR, WDATA, DATAR;
  logic [3:0]  AWLEN, ARLEN, WSTRB;
  logic [2:0]  AWSIZE, ARSIZE;
  logic [1:0]  AWBURST, ARBURST;
  logic        AWVALID, WLAST, WVALID, BREADY, ARVALID, RREADY, ACK;
  wire         AWREADY, WREADY, BVALID, ARREADY, RVALID, RLAST, REQ, WR;
  wire  [7:0]  BID, RID;
  wire  [1:0]  BRESP, RRESP;
  wire  [31:0] RDATA, ADDR, DATAW, checkErrors;
  wire  [3:0]  BE;

  int          seed = 32'h4140324a;
  int          failures;
  int          testsRun;
  int          testsFailed;
  int          lastTotal;
  logic        throttle;
  logic [31:0] targetMem[256];   // what the target really holds
  logic [31:0] refMem[256];      // expected contents

  axiApbBridge #(.idWidth(8), .addrWidth(32)) UUT (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .AWID(AWID), .AWADDR(AWADDR), .AWLEN(AWLEN), .AWSIZE(AWSIZE), .AWBURST(AWBURST),
    .AWVALID(AWVALID), .AWREADY(AWREADY),
    .WID(WID), .WDATA(WDATA), .WSTRB(WSTRB), .WLAST(WLAST), .WVALID(WVALID),
    .WREADY(WREADY), .BID(BID), .BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
    .ARID(ARID), .ARADDR(ARADDR), .ARLEN(ARLEN), .ARSIZE(ARSIZE), .ARBURST(ARBURST),
    .ARVALID(ARVALID), .ARREADY(ARREADY),
    .RID(RID), .RDATA(RDATA), .RRESP(RRESP), .RLAST(RLAST), .RVALID(RVALID),
    .RREADY(RREADY), .REQ(REQ), .ACK(ACK), .ADDR(ADDR), .WR(WR), .DATAW(DATAW),
    .DATAR(DATAR), .BE(BE)
  );

  tbChecker chk (
    .ACLK(ACLK), .ARESETn(ARESETn), .REQ(REQ), .ADDR(ADDR), .WR(WR), .DATAW(DATAW),
    .BE(BE), .BVALID(BVALID), .BREADY(BREADY), .BID(BID), .BRESP(BRESP),
    .RVALID(RVALID), .RREADY(RREADY), .RID(RID), .RDATA(RDATA), .RRESP(RRESP),
    .RLAST(RLAST), .errorCount(checkErrors)
  );

  always #10 ACLK = ~ACLK;

  // ready signals, randomly low when throttled
  always begin : readyThrottle
    @(posedge ACLK);
    #driveDelay;
    BREADY = !throttle || (($random(seed) & 3) != 0);
    RREADY = !throttle || (($random(seed) & 3) != 0);
  end

  // -------------------------------------------------------------------------
  // target memory, answers REQ after a random delay
  // -------------------------------------------------------------------------
  always begin : targetModel
    int         delay;
    int         cycles;
    logic [7:0] word;
    @(negedge ACLK);
    if (REQ && !ACK) begin
      delay = $random(seed) & 3;
      repeat (delay) @(negedge ACLK);
      @(posedge ACLK);
      #driveDelay;
      word  = ADDR[9:2];
      DATAR = targetMem[word];
      for (int b = 0; b < 4; b++) begin
        if (WR && BE[b]) targetMem[word][8*b +: 8] = DATAW[8*b +: 8];
      end
      ACK    = 1'b1;
      cycles = 0;
      do begin
        @(negedge ACLK);
        cycles++;
      end while (REQ && cycles < timeoutCycles);
      if (REQ) begin
        $display("timeout waiting for REQ to fall");
        failures++;
      end
      @(posedge ACLK);
      #driveDelay;
      ACK = 1'b0;
    end
  end

  function automatic bit handshakeSeen(input int sel);
    case (sel)
      awChan:  return AWREADY;
      wChan:   return WREADY;
      bChan:   return BVALID && BREADY;
      arChan:  return ARREADY;
      default: return RVALID && RREADY;
    endcase
  endfunction

  task automatic awaitHandshake(input int sel, input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge ACLK);
      cycles++;
    end while (!handshakeSeen(sel) && cycles < timeoutCycles);
    if (!handshakeSeen(sel)) begin
      $display("timeout waiting for %s", what);
      failures++;
    end
  endtask

  // INCR steps by size when narrow, else to the next word; others hold
  function automatic logic [31:0] nextBeatAddr(input logic [31:0] a, input logic [2:0] size,
                                               input logic [1:0] burst);
    if (burst != burstIncr) return a;
    if (size < 3'd2) return a + (32'd1 << size);
    return (a & ~32'd3) + 32'd4;
  endfunction

  function automatic logic [3:0] laneMask(input logic [31:0] a, input logic [2:0] size);
    if (size == 3'd0) return 4'b0001 << a[1:0];
    if (size == 3'd1) return 4'b0011 << a[1:0];
    return 4'b1111;
  endfunction

  // full-word write burst, badBeat < 0 means all WIDs match
  task automatic writeBurst(input logic [7:0] id, input logic [31:0] start, input int len,
                            input logic [1:0] burst, input int badBeat, input bit dropLast);
    logic [31:0] data[16];
    logic [31:0] a;
    a = start;
    for (int i = 0; i <= len; i++) begin
      data[i] = $random(seed);
      chk.expectTransfer(1'b1, a, data[i], 4'hf);
      refMem[a[9:2]] = data[i];
      a = nextBeatAddr(a, 3'd2, burst);
    end
    chk.expectWriteResp(id, (badBeat >= 0 || dropLast) ? respSlvErr : respOkay);
    @(posedge ACLK);
    #driveDelay;
    AWID    = id;
    AWADDR  = start;
    AWLEN   = 4'(len);
    AWSIZE  = 3'd2;
    AWBURST = burst;
    AWVALID = 1'b1;
    awaitHandshake(awChan, "AWREADY");
    @(posedge ACLK);
    #driveDelay;
    AWVALID = 1'b0;
    for (int i = 0; i <= len; i++) begin
      WID    = (i == badBeat) ? id ^ 8'h01 : id;
      WDATA  = data[i];
      WSTRB  = 4'hf;
      WLAST  = (i == len) && !dropLast;
      WVALID = 1'b1;
      awaitHandshake(wChan, "WREADY");
      @(posedge ACLK);
      #driveDelay;
      WVALID = 1'b0;
    end
    awaitHandshake(bChan, "BVALID");
  endtask

  task automatic readBurst(input logic [7:0] id, input logic [31:0] start, input int len,
                           input logic [2:0] size, input logic [1:0] burst);
    logic [31:0] a;
    @(posedge ACLK);
    a = start;   // expectations after the edge, so a parallel write goes first
    for (int i = 0; i <= len; i++) begin
      chk.expectTransfer(1'b0, a, 32'h0, laneMask(a, size));
      chk.expectReadBeat(id, refMem[a[9:2]], i == len);
      a = nextBeatAddr(a, size, burst);
    end
    #driveDelay;
    ARID    = id;
    ARADDR  = start;
    ARLEN   = 4'(len);
    ARSIZE  = size;
    ARBURST = burst;
    ARVALID = 1'b1;
    awaitHandshake(arChan, "ARREADY");
    @(posedge ACLK);
    #driveDelay;
    ARVALID = 1'b0;
    for (int i = 0; i <= len; i++) awaitHandshake(rChan, "RVALID");
  endtask

  task automatic finishTest(input string name);
    int errs;
    repeat (2) @(negedge ACLK);   // let the checker see the last handshake
    if (chk.outstanding() != 0) begin
      $display("%s: %0d expected transfers or beats never appeared", name,
               chk.outstanding());
      failures++;
    end
    errs      = int'(checkErrors) + failures - lastTotal;
    lastTotal = lastTotal + errs;
    testsRun++;
    if (errs != 0) begin
      testsFailed++;
      $display("test %0d %s: FAILED with %0d errors", testsRun, name, errs);
    end else begin
      $display("test %0d %s: ok", testsRun, name);
    end
  endtask

  // -------------------------------------------------------------------------
  // stimulus
  // -------------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] start;
    logic [31:0] start2;
    logic [2:0]  size;
    int          len;
    ACLK = 1'b0;
    ARESETn = 1'b0;
    {AWID, AWADDR, AWLEN, AWSIZE, AWBURST, AWVALID} = '0;
    {WID, WDATA, WSTRB, WLAST, WVALID} = '0;
    {ARID, ARADDR, ARLEN, ARSIZE, ARBURST, ARVALID} = '0;
    BREADY = 1'b1;
    RREADY = 1'b1;
    ACK = 1'b0;
    DATAR = '0;
    throttle = 1'b0;
    failures = 0;
    testsRun = 0;
    testsFailed = 0;
    lastTotal = 0;
    for (int i = 0; i < 256; i++) begin
      targetMem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 3)};
      refMem[i] = targetMem[i];
    end
    repeat (4) @(posedge ACLK);
    #driveDelay;
    ARESETn = 1'b1;

    repeat (8) begin   // idle bus, nothing may move
      @(negedge ACLK);
      chk.compareValue("AWREADY", 32'(AWREADY), 32'h0);
      chk.compareValue("WREADY", 32'(WREADY), 32'h0);
      chk.compareValue("ARREADY", 32'(ARREADY), 32'h0);
      chk.compareValue("BVALID", 32'(BVALID), 32'h0);
      chk.compareValue("RVALID", 32'(RVALID), 32'h0);
      chk.compareValue("RLAST", 32'(RLAST), 32'h0);
      chk.compareValue("REQ", 32'(REQ), 32'h0);
    end
    finishTest("reset and idle");

    for (int n = 0; n < burstTests; n++) begin
      start = $random(seed);
      start[1:0] = 2'b00;
      len = (n < 2) ? 0 : ($random(seed) & 15);   // first two are single beats
      writeBurst(8'($random(seed)), start, len, burstIncr, -1, 1'b0);
      readBurst(8'($random(seed)), start, len, 3'd2, burstIncr);
    end
    finishTest("incr write and read back");

    for (int n = 0; n < burstTests; n++) begin
      start = $random(seed);
      size = 3'($random(seed) & 1);
      if (size == 3'd1) start[0] = 1'b0;
      readBurst(8'(n), start, $random(seed) & 15, size, burstIncr);
    end
    start = $random(seed);
    start[1:0] = 2'b00;
    writeBurst(8'h33, start, 3, burstFixed, -1, 1'b0);
    readBurst(8'h34, start, 3, 3'd2, burstFixed);
    finishTest("narrow and fixed bursts");

    start = $random(seed);
    start[1:0] = 2'b00;
    writeBurst(8'h5a, start, 2, burstIncr, 1, 1'b0);    // bad WID on beat 1
    writeBurst(8'h6b, start, 2, burstIncr, -1, 1'b1);   // no WLAST
    writeBurst(8'h7c, start, 2, burstIncr, -1, 1'b0);
    finishTest("write responses");

    throttle = 1'b1;
    for (int n = 0; n < 4; n++) begin
      start = $random(seed);
      start[1:0] = 2'b00;
      start2 = (n[0]) ? start : $random(seed);   // same region every other pass
      start2[1:0] = 2'b00;
      len = $random(seed) & 15;
      fork
        writeBurst(8'($random(seed)), start, len, burstIncr, -1, 1'b0);
        readBurst(8'($random(seed)), start2, $random(seed) & 15, 3'd2, burstIncr);
      join
    end
    throttle = 1'b0;
    finishTest("write priority and back-pressure");

    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, lastTotal);
    if (testsFailed == 0 && lastTotal == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
rtl/axiBridgePkg.sv
rtl/transferPort.sv
rtl/burstAddressCounter.sv
rtl/writeChannelFsm.sv
rtl/readChannelFsm.sv
rtl/axiApbBridge.sv
sim/tbChecker.sv
sim/tbAxiApbBridge.sv

// File: Makefile
VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := tbAxiApbBridge
RTL_TOP    := axiApbBridge
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(OBJ_DIR)
PASS_MSG   := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
